// File: logic/decode_pkg.sv
package decode_pkg;

  // ##################################################
  // Basic widths.
  // ##################################################

  typedef logic [31:0] instr_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [31:0] word_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [2:0] {
    mem_none,
    mem_byte,
    mem_half,
    mem_word,
    mem_byte_u,
    mem_half_u
  } mem_op_t;

  // Machine exception causes as listed in the privileged spec.
  typedef logic [3:0] cause_t;

  localparam cause_t cause_illegal = 4'd2;
  localparam cause_t cause_breakpoint = 4'd3;
  localparam cause_t cause_ecall_m = 4'd11;

  // ##################################################
  // Decoded results.
  // ##################################################

  typedef struct packed {
    logic valid;
    logic wren;
    logic rden1;
    logic rden2;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic fence;
    logic ecall;
    logic ebreak;
    alu_op_t alu_op;
    mem_op_t mem_op;
    word_t imm;
  } decoder_out_t;

  typedef struct packed {
    addr_t pc;
    instr_t instr;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    decoder_out_t dec;
    word_t rdata1;
    word_t rdata2;
    logic exception;
    cause_t ecause;
    word_t etval;
  } slot_t;

  typedef struct packed {
    slot_t slot0;
    slot_t slot1;
    logic stall;
  } decode_out_t;

  typedef struct packed {
    logic load;
    reg_addr_t waddr;
  } exec_hint_t;

  typedef struct packed {
    logic wren;
    reg_addr_t waddr;
    word_t wdata;
  } reg_write_t;

  localparam decoder_out_t init_decoder_out = '{alu_op: alu_add, mem_op: mem_none, default: '0};
  localparam slot_t init_slot = '{dec: init_decoder_out, default: '0};
  localparam decode_out_t init_decode_out = '{slot0: init_slot, slot1: init_slot, stall: 1'b0};

endpackage

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder #(
  parameter bit alu_only = 1'b0
) (
  input decode_pkg::instr_t instr,
  output decode_pkg::decoder_out_t result
);

  import decode_pkg::*;

  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jal = 7'b1101111;
  localparam logic [6:0] opc_jalr = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_fence = 7'b0001111;
  localparam logic [6:0] opc_system = 7'b1110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  decoder_out_t dec;
  logic legal;
  logic alu_class;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign alu_class = (opcode == opc_op) || (opcode == opc_op_imm) || (opcode == opc_lui);

  always_comb begin
    dec = init_decoder_out;
    legal = 1'b1;
    case (opcode)
      opc_lui: begin
        dec.lui = 1'b1;
        dec.wren = 1'b1;
        dec.imm = imm_u;
      end
      opc_auipc: begin
        dec.auipc = 1'b1;
        dec.wren = 1'b1;
        dec.imm = imm_u;
      end
      opc_jal: begin
        dec.jal = 1'b1;
        dec.wren = 1'b1;
        dec.imm = imm_j;
      end
      opc_jalr: begin
        dec.jalr = 1'b1;
        dec.wren = 1'b1;
        dec.rden1 = 1'b1;
        dec.imm = imm_i;
        legal = (funct3 == 3'b000);
      end
      opc_branch: begin
        dec.branch = 1'b1;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.imm = imm_b;
        // Compare operation for the branch unit.
        dec.alu_op = funct3[2] ? (funct3[1] ? alu_sltu : alu_slt) : alu_sub;
        legal = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      opc_load: begin
        dec.load = 1'b1;
        dec.wren = 1'b1;
        dec.rden1 = 1'b1;
        dec.imm = imm_i;
        case (funct3)
          3'b000: dec.mem_op = mem_byte;
          3'b001: dec.mem_op = mem_half;
          3'b010: dec.mem_op = mem_word;
          3'b100: dec.mem_op = mem_byte_u;
          3'b101: dec.mem_op = mem_half_u;
          default: legal = 1'b0;
        endcase
      end
      opc_store: begin
        dec.store = 1'b1;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.imm = imm_s;
        case (funct3)
          3'b000: dec.mem_op = mem_byte;
          3'b001: dec.mem_op = mem_half;
          3'b010: dec.mem_op = mem_word;
          default: legal = 1'b0;
        endcase
      end
      opc_op_imm, opc_op: begin
        dec.wren = 1'b1;
        dec.rden1 = 1'b1;
        dec.rden2 = (opcode == opc_op);
        dec.imm = (opcode == opc_op) ? '0 : imm_i;
        case (funct3)
          3'b000: dec.alu_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
          3'b001: dec.alu_op = alu_sll;
          3'b010: dec.alu_op = alu_slt;
          3'b011: dec.alu_op = alu_sltu;
          3'b100: dec.alu_op = alu_xor;
          3'b101: dec.alu_op = funct7[5] ? alu_sra : alu_srl;
          3'b110: dec.alu_op = alu_or;
          default: dec.alu_op = alu_and;
        endcase
        // Only sub and sra carry funct7 bit 5; immediates check funct7 on shifts alone.
        if (opcode == opc_op || funct3 == 3'b001 || funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b101 ||
                                            (funct3 == 3'b000 && opcode == opc_op)));
        end
      end
      opc_fence: begin
        dec.fence = 1'b1;
        legal = (funct3 == 3'b000);
      end
      opc_system: begin
        dec.ecall = (instr == 32'h0000_0073);
        dec.ebreak = (instr == 32'h0010_0073);
        legal = dec.ecall || dec.ebreak;
      end
      default: legal = 1'b0;
    endcase

    if (!legal || (alu_only && !alu_class)) begin
      result = init_decoder_out;
    end else begin
      result = dec;
      result.valid = 1'b1;
    end
  end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
  input logic clock,
  input logic reset,
  input decode_pkg::reg_addr_t raddr [4],
  output decode_pkg::word_t rdata [4],
  input decode_pkg::reg_write_t write
);

  import decode_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write.wren && write.waddr != '0) begin
      regs[write.waddr] <= write.wdata;
    end
  end

  // A write in the same cycle is forwarded so decode sees the new value.
  always_comb begin
    for (int p = 0; p < 4; p++) begin
      if (raddr[p] == '0) begin
        rdata[p] = '0;
      end else if (write.wren && write.waddr == raddr[p]) begin
        rdata[p] = write.wdata;
      end else begin
        rdata[p] = regs[raddr[p]];
      end
    end
  end

  // ##################################################
  // x0 stays zero after a write to it.
  // ##################################################

  assert property (@(posedge clock) disable iff (!reset)
    (write.wren && write.waddr == '0) |=> (regs[0] == '0))
    else $error("register_file: x0 storage changed");

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input logic clock,
  input logic reset,
  input decode_pkg::addr_t pc0,
  input decode_pkg::addr_t pc1,
  input decode_pkg::instr_t instr0,
  input decode_pkg::instr_t instr1,
  input logic fetch_valid,
  input decode_pkg::decoder_out_t dec0,
  input decode_pkg::decoder_out_t dec1,
  input decode_pkg::exec_hint_t exec,
  input logic flush,
  input logic hold,
  output decode_pkg::reg_addr_t raddr [4],
  input decode_pkg::word_t rdata [4],
  output decode_pkg::decode_out_t decoded,
  output logic stall
);

  import decode_pkg::*;

  decode_out_t r;
  decode_out_t nxt;
  logic hazard;

  function automatic slot_t make_slot(addr_t pc, instr_t instr, decoder_out_t dec,
                                      word_t data1, word_t data2);
    slot_t s;
    s = init_slot;
    s.pc = pc;
    s.instr = instr;
    s.waddr = instr[11:7];
    s.raddr1 = instr[19:15];
    s.raddr2 = instr[24:20];
    s.dec = dec;
    s.rdata1 = data1;
    s.rdata2 = data2;
    return s;
  endfunction

  // Clears every flag of a slot but keeps pc, instruction and operands for debug.
  function automatic slot_t bubble(slot_t s);
    slot_t b;
    b = s;
    b.dec = init_decoder_out;
    b.exception = 1'b0;
    b.ecause = '0;
    b.etval = '0;
    return b;
  endfunction

  // Disabled sources read x0, so they can never match a load destination.
  assign raddr[0] = dec0.rden1 ? instr0[19:15] : '0;
  assign raddr[1] = dec0.rden2 ? instr0[24:20] : '0;
  assign raddr[2] = dec1.rden1 ? instr1[19:15] : '0;
  assign raddr[3] = dec1.rden2 ? instr1[24:20] : '0;

  always_comb begin
    hazard = 1'b0;
    if (exec.load && exec.waddr != '0) begin
      for (int i = 0; i < 4; i++) begin
        if (raddr[i] == exec.waddr) begin
          hazard = 1'b1;
        end
      end
    end
  end

  assign stall = hazard && !flush && !hold;

  always_comb begin
    nxt.slot0 = make_slot(pc0, instr0, dec0, rdata[0], rdata[1]);
    nxt.slot1 = make_slot(pc1, instr1, dec1, rdata[2], rdata[3]);
    nxt.stall = stall;

    if (!dec0.valid) begin
      nxt.slot0.exception = 1'b1;
      nxt.slot0.ecause = cause_illegal;
    end else if (dec0.ebreak) begin
      nxt.slot0.exception = 1'b1;
      nxt.slot0.ecause = cause_breakpoint;
    end else if (dec0.ecall) begin
      nxt.slot0.exception = 1'b1;
      nxt.slot0.ecause = cause_ecall_m;
    end
    if (nxt.slot0.exception) begin
      nxt.slot0.etval = instr0;
    end

    if (!dec1.valid) begin
      nxt.slot1 = bubble(nxt.slot1);
    end

    if (stall || !fetch_valid) begin
      nxt.slot0 = bubble(nxt.slot0);
      nxt.slot1 = bubble(nxt.slot1);
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      r <= init_decode_out;
    end else if (!hold) begin
      r <= nxt;
    end
  end

  assign decoded = r;

  // A stalled pair is never issued, so execute sees a bubble on the next cycle.
  assert property (@(posedge clock) disable iff (!reset)
    stall |-> !(flush || hold) ##1
      (!decoded.slot0.dec.valid && !decoded.slot1.dec.valid && !decoded.slot0.exception))
    else $error("decode_stage: stall did not produce a bubble");

endmodule

// File: logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
  input logic clock,
  input logic reset,
  input decode_pkg::addr_t pc0,
  input decode_pkg::addr_t pc1,
  input decode_pkg::instr_t instr0,
  input decode_pkg::instr_t instr1,
  input logic fetch_valid,
  input decode_pkg::exec_hint_t exec,
  input decode_pkg::reg_write_t write,
  input logic flush,
  input logic hold,
  output decode_pkg::decode_out_t decoded,
  output logic stall
);

  import decode_pkg::*;

  decoder_out_t dec0;
  decoder_out_t dec1;
  reg_addr_t raddr [4];
  word_t rdata [4];

  // Slot 0 takes the full integer set, slot 1 only ALU work.
  instr_decoder #(
    .alu_only(1'b0)
  ) decoder0_inst (
    .instr(instr0),
    .result(dec0)
  );

  instr_decoder #(
    .alu_only(1'b1)
  ) decoder1_inst (
    .instr(instr1),
    .result(dec1)
  );

  register_file register_file_inst (
    .clock(clock),
    .reset(reset),
    .raddr(raddr),
    .rdata(rdata),
    .write(write)
  );

  decode_stage decode_stage_inst (
    .clock(clock),
    .reset(reset),
    .pc0(pc0),
    .pc1(pc1),
    .instr0(instr0),
    .instr1(instr1),
    .fetch_valid(fetch_valid),
    .dec0(dec0),
    .dec1(dec1),
    .exec(exec),
    .flush(flush),
    .hold(hold),
    .raddr(raddr),
    .rdata(rdata),
    .decoded(decoded),
    .stall(stall)
  );

endmodule

// File: verification/decode_checker.sv
`timescale 1ns/1ps

module decode_checker (
  input logic clock,
  input logic reset,
  input decode_pkg::addr_t pc0,
  input decode_pkg::addr_t pc1,
  input decode_pkg::instr_t instr0,
  input decode_pkg::instr_t instr1,
  input logic fetch_valid,
  input decode_pkg::exec_hint_t exec,
  input decode_pkg::reg_write_t write,
  input logic flush,
  input logic hold,
  input decode_pkg::decode_out_t decoded,
  input logic stall
);

  import decode_pkg::*;

  localparam int cat_decode = 0;
  localparam int cat_operand = 1;
  localparam int cat_exception = 2;
  localparam int cat_stall = 3;
  localparam int cat_control = 4;

  int error_count [5];
  int check_count;
  word_t model_regs [32];
  decode_out_t expected;
  logic expected_ctl;
  logic armed;

  initial begin
    for (int i = 0; i < 5; i++) begin
      error_count[i] = 0;
    end
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    check_count = 0;
    expected = init_decode_out;
    expected_ctl = 1'b1;
    armed = 1'b0;
  end

  function automatic string test_name(int cat);
    case (cat)
      cat_decode: return "decode_fields";
      cat_operand: return "operands";
      cat_exception: return "exceptions";
      cat_stall: return "load_use_stall";
      default: return "flush_hold_reset";
    endcase
  endfunction

  task automatic compare(input int cat, input string name, input logic [63:0] exp,
                         input logic [63:0] act);
    check_count++;
    if (exp !== act) begin
      error_count[cat]++;
      $display("** Error %s %s: expected %h, actual %h at %0t",
               test_name(cat), name, exp, act, $time);
    end
  endtask

  // ##################################################
  // Reference decode built from the RV32I tables.
  // ##################################################

  function automatic alu_op_t alu_for_funct3(logic [2:0] f3, logic alt);
    case (f3)
      3'b000: return alt ? alu_sub : alu_add;
      3'b001: return alu_sll;
      3'b010: return alu_slt;
      3'b011: return alu_sltu;
      3'b100: return alu_xor;
      3'b101: return alt ? alu_sra : alu_srl;
      3'b110: return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic decoder_out_t predict_decode(instr_t w, logic alu_only);
    decoder_out_t d;
    logic [2:0] f3;
    logic [6:0] f7;
    logic ok;
    logic alu_kind;
    d = '0;
    f3 = w[14:12];
    f7 = w[31:25];
    ok = 1'b1;
    alu_kind = 1'b0;
    case (w[6:0])
      7'b0110111: begin
        d.lui = 1'b1;
        d.wren = 1'b1;
        d.imm = {w[31:12], 12'h000};
        alu_kind = 1'b1;
      end
      7'b0010111: begin
        d.auipc = 1'b1;
        d.wren = 1'b1;
        d.imm = {w[31:12], 12'h000};
      end
      7'b1101111: begin
        d.jal = 1'b1;
        d.wren = 1'b1;
        d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100111: begin
        d.jalr = 1'b1;
        d.wren = 1'b1;
        d.rden1 = 1'b1;
        d.imm = {{20{w[31]}}, w[31:20]};
        ok = (f3 == 3'b000);
      end
      7'b1100011: begin
        d.branch = 1'b1;
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        // beq/bne compare by subtraction, blt/bge signed, bltu/bgeu unsigned.
        case (f3)
          3'b000, 3'b001: d.alu_op = alu_sub;
          3'b100, 3'b101: d.alu_op = alu_slt;
          3'b110, 3'b111: d.alu_op = alu_sltu;
          default: ok = 1'b0;
        endcase
      end
      7'b0000011: begin
        d.load = 1'b1;
        d.wren = 1'b1;
        d.rden1 = 1'b1;
        d.imm = {{20{w[31]}}, w[31:20]};
        case (f3)
          3'b000: d.mem_op = mem_byte;
          3'b001: d.mem_op = mem_half;
          3'b010: d.mem_op = mem_word;
          3'b100: d.mem_op = mem_byte_u;
          3'b101: d.mem_op = mem_half_u;
          default: ok = 1'b0;
        endcase
      end
      7'b0100011: begin
        d.store = 1'b1;
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        case (f3)
          3'b000: d.mem_op = mem_byte;
          3'b001: d.mem_op = mem_half;
          3'b010: d.mem_op = mem_word;
          default: ok = 1'b0;
        endcase
      end
      7'b0010011: begin
        d.wren = 1'b1;
        d.rden1 = 1'b1;
        d.imm = {{20{w[31]}}, w[31:20]};
        d.alu_op = alu_for_funct3(f3, f3 == 3'b101 && f7 == 7'b0100000);
        if (f3 == 3'b001) begin
          ok = (f7 == 7'b0000000);
        end else if (f3 == 3'b101) begin
          ok = (f7 == 7'b0000000) || (f7 == 7'b0100000);
        end
        alu_kind = 1'b1;
      end
      7'b0110011: begin
        d.wren = 1'b1;
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.alu_op = alu_for_funct3(f3, f7 == 7'b0100000);
        ok = (f7 == 7'b0000000) ||
             (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
        alu_kind = 1'b1;
      end
      7'b0001111: begin
        d.fence = 1'b1;
        ok = (f3 == 3'b000);
      end
      7'b1110011: begin
        d.ecall = (w == 32'h0000_0073);
        d.ebreak = (w == 32'h0010_0073);
        ok = d.ecall || d.ebreak;
      end
      default: ok = 1'b0;
    endcase
    if (!ok || (alu_only && !alu_kind)) begin
      d = '0;
    end else begin
      d.valid = 1'b1;
    end
    return d;
  endfunction

  // Disabled sources read as zero; a same-cycle writeback wins over the array.
  function automatic word_t read_operand(reg_addr_t a, logic en);
    if (!en || a == 5'd0) begin
      return '0;
    end
    if (write.wren && write.waddr == a) begin
      return write.wdata;
    end
    return model_regs[a];
  endfunction

  function automatic slot_t predict_slot(addr_t pc, instr_t w, logic second);
    slot_t s;
    s = '0;
    s.pc = pc;
    s.instr = w;
    s.waddr = w[11:7];
    s.raddr1 = w[19:15];
    s.raddr2 = w[24:20];
    s.dec = predict_decode(w, second);
    s.rdata1 = read_operand(w[19:15], s.dec.rden1);
    s.rdata2 = read_operand(w[24:20], s.dec.rden2);
    if (!second) begin
      s.exception = 1'b1;
      if (!s.dec.valid) begin
        s.ecause = 4'd2;
      end else if (s.dec.ebreak) begin
        s.ecause = 4'd3;
      end else if (s.dec.ecall) begin
        s.ecause = 4'd11;
      end else begin
        s.exception = 1'b0;
      end
      s.etval = s.exception ? w : '0;
    end
    return s;
  endfunction

  function automatic slot_t make_bubble(slot_t s);
    slot_t b;
    b = s;
    b.dec = '0;
    b.exception = 1'b0;
    b.ecause = '0;
    b.etval = '0;
    return b;
  endfunction

  function automatic logic predict_hazard(decoder_out_t d0, decoder_out_t d1);
    if (!exec.load || exec.waddr == 5'd0) begin
      return 1'b0;
    end
    return (d0.rden1 && instr0[19:15] == exec.waddr) ||
           (d0.rden2 && instr0[24:20] == exec.waddr) ||
           (d1.rden1 && instr1[19:15] == exec.waddr) ||
           (d1.rden2 && instr1[24:20] == exec.waddr);
  endfunction

  task automatic compare_slot(input string name, input slot_t exp, input slot_t act,
                              input logic ctl);
    int c_dec;
    int c_opd;
    int c_exc;
    c_dec = ctl ? cat_control : cat_decode;
    c_opd = ctl ? cat_control : cat_operand;
    c_exc = ctl ? cat_control : cat_exception;
    if (exp.dec.valid || exp.exception) begin
      compare(c_dec, {name, ".pc"}, 64'(exp.pc), 64'(act.pc));
      compare(c_dec, {name, ".instr"}, 64'(exp.instr), 64'(act.instr));
      compare(c_dec, {name, ".waddr"}, 64'(exp.waddr), 64'(act.waddr));
      compare(c_dec, {name, ".raddr1"}, 64'(exp.raddr1), 64'(act.raddr1));
      compare(c_dec, {name, ".raddr2"}, 64'(exp.raddr2), 64'(act.raddr2));
      compare(c_dec, {name, ".dec"}, 64'(exp.dec), 64'(act.dec));
      compare(c_opd, {name, ".rdata1"}, 64'(exp.rdata1), 64'(act.rdata1));
      compare(c_opd, {name, ".rdata2"}, 64'(exp.rdata2), 64'(act.rdata2));
      compare(c_exc, {name, ".ecause"}, 64'(exp.ecause), 64'(act.ecause));
      compare(c_exc, {name, ".etval"}, 64'(exp.etval), 64'(act.etval));
    end else begin
      compare(c_dec, {name, ".dec"}, 64'(exp.dec), 64'(act.dec));
    end
    compare(c_exc, {name, ".exception"}, 64'(exp.exception), 64'(act.exception));
  endtask

  // Outputs settle between the drive after one rising edge and the next one.
  always @(negedge clock) begin : watch
    decoder_out_t d0;
    decoder_out_t d1;
    decode_out_t nxt;
    logic exp_stall;
    if (armed) begin
      compare_slot("slot0", expected.slot0, decoded.slot0, expected_ctl);
      compare_slot("slot1", expected.slot1, decoded.slot1, expected_ctl);
      compare(expected_ctl ? cat_control : cat_stall, "decoded.stall",
              64'(expected.stall), 64'(decoded.stall));
    end
    d0 = predict_decode(instr0, 1'b0);
    d1 = predict_decode(instr1, 1'b1);
    exp_stall = predict_hazard(d0, d1) && !flush && !hold;
    compare(cat_stall, "stall", 64'(exp_stall), 64'(stall));

    if (!reset || flush) begin
      expected = init_decode_out;
      expected_ctl = 1'b1;
    end else if (hold) begin
      expected_ctl = 1'b1;
    end else begin
      nxt.slot0 = predict_slot(pc0, instr0, 1'b0);
      nxt.slot1 = predict_slot(pc1, instr1, 1'b1);
      nxt.stall = exp_stall;
      if (exp_stall || !fetch_valid) begin
        nxt.slot0 = make_bubble(nxt.slot0);
        nxt.slot1 = make_bubble(nxt.slot1);
      end
      expected = nxt;
      expected_ctl = 1'b0;
    end

    if (!reset) begin
      for (int r = 0; r < 32; r++) begin
        model_regs[r] = '0;
      end
    end else if (write.wren && write.waddr != 5'd0) begin
      model_regs[write.waddr] = write.wdata;
    end
    armed = 1'b1;
  end

endmodule

// File: include/rv_encodings.svh
`ifndef RV_ENCODINGS_SVH
`define RV_ENCODINGS_SVH

// Random legal RV32I word; register fields and immediates stay random.
function automatic logic [31:0] rv_legal_instr();
  logic [31:0] w;
  logic [2:0] f3;
  w = $urandom;
  f3 = 3'($urandom_range(0, 7));
  case ($urandom_range(0, 11))
    0: begin
      w[31:25] = ((f3 == 3'b000 || f3 == 3'b101) && w[30]) ? 7'b0100000 : 7'b0000000;
      w[14:12] = f3;
      w[6:0] = 7'b0110011;
    end
    1: begin
      if (f3 == 3'b001) begin
        w[31:25] = 7'b0000000;
      end else if (f3 == 3'b101) begin
        w[31:25] = w[30] ? 7'b0100000 : 7'b0000000;
      end
      w[14:12] = f3;
      w[6:0] = 7'b0010011;
    end
    2: w[6:0] = 7'b0110111;
    3: w[6:0] = 7'b0010111;
    4: w[6:0] = 7'b1101111;
    5: begin
      w[14:12] = 3'b000;
      w[6:0] = 7'b1100111;
    end
    6: begin
      w[14:12] = (f3 == 3'b010 || f3 == 3'b011) ? 3'b000 : f3;
      w[6:0] = 7'b1100011;
    end
    7: begin
      w[14:12] = (f3 == 3'b011 || f3 > 3'b101) ? 3'b010 : f3;
      w[6:0] = 7'b0000011;
    end
    8: begin
      w[14:12] = (f3 > 3'b010) ? 3'b010 : f3;
      w[6:0] = 7'b0100011;
    end
    9: begin
      w[14:12] = 3'b000;
      w[6:0] = 7'b0001111;
    end
    10: w = 32'h0000_0073;
    default: w = 32'h0010_0073;
  endcase
  return w;
endfunction

// Encodings that no decoder slot accepts.
function automatic logic [31:0] rv_illegal_instr();
  logic [31:0] w;
  w = $urandom;
  case ($urandom_range(0, 2))
    0: w[1:0] = 2'b00;
    1: begin
      w[31:25] = 7'b0000001;
      w[6:0] = 7'b0110011;
    end
    default: begin
      w[14:12] = 3'b010;
      w[6:0] = 7'b1100011;
    end
  endcase
  return w;
endfunction

function automatic logic [31:0] rv_rand_instr(int unsigned illegal_pct);
  return ($urandom_range(0, 99) < illegal_pct) ? rv_illegal_instr() : rv_legal_instr();
endfunction

`endif

// File: verification/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;

  import decode_pkg::*;

  `include "rv_encodings.svh"

  localparam int num_cycles = 3000;
  localparam int wait_limit = 50;

  logic clock;
  logic reset;
  addr_t pc0;
  addr_t pc1;
  instr_t instr0;
  instr_t instr1;
  logic fetch_valid;
  exec_hint_t exec;
  reg_write_t write;
  logic flush;
  logic hold;
  decode_out_t decoded;
  logic stall;

  addr_t next_pc;
  int timeout_count;

  decode_unit decode_unit_inst (
    .clock(clock),
    .reset(reset),
    .pc0(pc0),
    .pc1(pc1),
    .instr0(instr0),
    .instr1(instr1),
    .fetch_valid(fetch_valid),
    .exec(exec),
    .write(write),
    .flush(flush),
    .hold(hold),
    .decoded(decoded),
    .stall(stall)
  );

  decode_checker checker_inst (
    .clock(clock),
    .reset(reset),
    .pc0(pc0),
    .pc1(pc1),
    .instr0(instr0),
    .instr1(instr1),
    .fetch_valid(fetch_valid),
    .exec(exec),
    .write(write),
    .flush(flush),
    .hold(hold),
    .decoded(decoded),
    .stall(stall)
  );

  always #4 clock = ~clock;

  task automatic new_pair();
    pc0 = next_pc;
    pc1 = next_pc + 32'd4;
    next_pc = next_pc + 32'd8;
    instr0 = rv_rand_instr(10);
    instr1 = rv_rand_instr(10);
  endtask

  // Called just after a rising edge, so stall and hold still show what that edge saw.
  task automatic drive_cycle();
    reg_addr_t src;
    int pick;
    if (!stall && !hold) begin
      new_pair();
    end
    fetch_valid = ($urandom_range(0, 99) >= 3);
    write.wren = ($urandom_range(0, 99) < 30);
    write.waddr = 5'($urandom);
    write.wdata = $urandom;
    pick = $urandom_range(0, 99);
    case ($urandom_range(0, 3))
      0: src = instr0[19:15];
      1: src = instr0[24:20];
      2: src = instr1[19:15];
      default: src = instr1[24:20];
    endcase
    exec.load = (pick < 25);
    exec.waddr = (pick < 15) ? src : 5'($urandom);
    flush = ($urandom_range(0, 99) < 5);
    hold = ($urandom_range(0, 99) < 10);
  endtask

  task automatic wait_stall_low(input string what);
    logic ok;
    ok = 1'b0;
    for (int n = 0; n < wait_limit && !ok; n++) begin
      @(posedge clock);
      ok = !stall;
    end
    if (!ok) begin
      $display("Timeout: stall stayed high for %0d cycles %s", wait_limit, what);
      timeout_count++;
    end
  endtask

  initial begin
    int total;
    void'($urandom(32'h27b9935d));
    clock = 1'b0;
    reset = 1'b0;
    pc0 = '0;
    pc1 = '0;
    instr0 = '0;
    instr1 = '0;
    fetch_valid = 1'b0;
    exec = '0;
    write = '0;
    flush = 1'b0;
    hold = 1'b0;
    next_pc = 32'h0000_1000;
    timeout_count = 0;

    repeat (5) @(posedge clock);
    #1;
    reset = 1'b1;
    wait_stall_low("after reset");

    for (int i = 0; i < num_cycles; i++) begin
      @(posedge clock);
      #1;
      drive_cycle();
    end

    // Drain with a quiet execute stage so the last pair leaves the stage.
    @(posedge clock);
    #1;
    exec = '0;
    write = '0;
    flush = 1'b0;
    hold = 1'b0;
    fetch_valid = 1'b0;
    wait_stall_low("at end of run");
    repeat (2) @(posedge clock);

    total = timeout_count;
    for (int c = 0; c < 5; c++) begin
      total += checker_inst.error_count[c];
    end
    $write("checks %0d: decode %0d, operands %0d, exceptions %0d, ",
           checker_inst.check_count, checker_inst.error_count[0],
           checker_inst.error_count[1], checker_inst.error_count[2]);
    $display("stall %0d, control %0d, timeouts %0d",
             checker_inst.error_count[3], checker_inst.error_count[4], timeout_count);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
logic/decode_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/decode_stage.sv
logic/decode_unit.sv
verification/decode_checker.sv
verification/decode_tb.sv

// File: Makefile
SOURCES := $(filter %.sv,$(shell cat build.f)) $(wildcard include/*.svh)

.PHONY: run clean

obj_dir/Vdecode_tb: build.f $(SOURCES)
	verilator --binary --timing -Iinclude --top-module decode_tb -f build.f

run: obj_dir/Vdecode_tb
	obj_dir/Vdecode_tb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
